// File: verilog/x1_pkg.sv
/* shared types for the x1 glue logic: cpu bus, device read path, sd/mmc spi port
   read strobes are active low as on the z80 bus, chip selects active high */
package x1_pkg;

  // ------------------------------------------------------------
  // cpu bus
  // ------------------------------------------------------------
  typedef logic [15:0] bus_addr_t;   // z80 address
  typedef logic [7:0]  bus_data_t;   // z80 data byte

  // cpu bus as seen by the glue logic, 26 bits
  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;                // cpu write data
    logic      rd_n;
    logic      wr_n;
  } cpu_bus_t;

  // read enables, from the external decoder and devices
  typedef struct packed {
    logic fdc_cs;                    // 5" fdc
    logic sub_doe;                   // sub cpu drives data
    logic pia_cs;                    // 8255
    logic psg_cs;                    // ay-3-8910 / joystick
    logic exrom_cs;                  // expansion rom window, spi port here
    logic mem_cs;                    // ipl | main ram | gram planes, or'ed outside
  } dev_sel_t;

  // read bytes of the external devices, 40 bits
  typedef struct packed {
    bus_data_t fdc;
    bus_data_t sub;
    bus_data_t pia;
    bus_data_t psg;
    bus_data_t mem;
  } dev_rdata_t;

  // idle data bus, pull-ups and and-tie
  localparam bus_data_t BUS_FREE = 8'hff;

  // ------------------------------------------------------------
  // spi port and clocking
  // ------------------------------------------------------------
  typedef logic [3:0] spi_count_t;   // bits left in transfer
  typedef logic [1:0] spi_sel_t;     // [1] mmc card, [0] config rom (no device)
  typedef logic [2:0] clk_phase_t;   // cpu clock divider phase, 8 per cpu cycle

  // bit sequencer
  typedef enum logic [1:0] {
    spi_idle,
    spi_clk_low,                     // bit pending, sclk low
    spi_clk_high                     // sclk high, card bit taken
  } spi_state_t;

endpackage

// File: verilog/clock_reset_gen.sv
/* cpu clock is clk32M/8 with rise and fall strobes one cycle ahead of the edge
   sys_reset holds 16 cycles past clk_reset and follows ipl_n low at once */
module clock_reset_gen #(
  parameter x1_pkg::clk_phase_t RISE_PHASE = 3'd6,  // phase before cpu_clk rise
  parameter x1_pkg::clk_phase_t FALL_PHASE = 3'd2   // phase before cpu_clk fall
) (
  input  logic clk32M,
  input  logic clk_reset,
  input  logic ipl_n,         // ipl reset button, low active
  output logic cpu_clk,       // 4 MHz
  output logic cpu_rise,      // 1 cycle strobe, cpu_clk rises next cycle
  output logic cpu_fall,      // 1 cycle strobe, cpu_clk falls next cycle
  output logic clk2M,
  output logic sys_reset
);
  import x1_pkg::*;

  logic [3:0] base_cnt;       // free running, clk2M and reset delay
  clk_phase_t phase;
  logic       reset_dly;

  // ------------------------------------------------------------
  // base counter
  // ------------------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
      base_cnt <= 4'h0;
    else
      base_cnt <= base_cnt + 4'h1;
  end

  assign clk2M = base_cnt[3];  // 16 cycle period

  // power-on reset stretch, released at the first counter wrap
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
      reset_dly <= 1'b1;
    else if (base_cnt == 4'hf)
      reset_dly <= 1'b0;
  end

  assign sys_reset = reset_dly | ~ipl_n;  // ipl button bypasses the delay

  // ------------------------------------------------------------
  // cpu clock divider
  // ------------------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      phase    <= '0;
      cpu_rise <= 1'b0;
      cpu_fall <= 1'b0;
      cpu_clk  <= 1'b0;
    end
    else
    begin
      // wraps every 8 cycles, back at zero right after a rise pulse at the default phases
      phase    <= phase + 3'd1;
      cpu_rise <= (phase == RISE_PHASE);
      cpu_fall <= (phase == FALL_PHASE);
      // level follows the strobes one cycle later
      if (cpu_rise)
        cpu_clk <= 1'b1;
      else if (cpu_fall)
        cpu_clk <= 1'b0;
    end
  end

  // strobes from one phase counter, distinct phases never meet
  a_edges_apart: assert property (@(posedge clk32M) disable iff (clk_reset)
    !(cpu_rise && cpu_fall));

endmodule

// File: verilog/spi_bit_fsm.sv
/* bit sequencer of the spi port in the expansion rom window
   a port write loads the bit count from addr[3:0], 2 clk32M cycles per bit */
module spi_bit_fsm (
  input  logic             clk32M,
  input  logic             clk_reset,
  input  logic             sys_reset,   // sync clear
  input  x1_pkg::cpu_bus_t bus,
  input  logic             exrom_cs,
  output logic             load,        // port write in progress
  output logic             shift,       // take card bit, sclk rises next
  output logic             sclk
);
  import x1_pkg::*;

  spi_state_t state;
  spi_count_t count;          // bits still to clock
  logic       port_wr;

  // ------------------------------------------------------------
  // port write decode
  // ------------------------------------------------------------
  assign port_wr = exrom_cs & ~bus.wr_n;
  assign load    = port_wr;           // held for the whole write

  // a write or a reset cancels a pending bit
  assign shift = (state == spi_clk_low) & ~port_wr & ~sys_reset;

  // ------------------------------------------------------------
  // sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      state <= spi_idle;
      count <= '0;
      sclk  <= 1'b0;
    end
    else if (sys_reset)
    begin
      state <= spi_idle;
      count <= '0;
      sclk  <= 1'b0;
    end
    else if (port_wr)
    begin
      count <= bus.addr[3:0];         // reloaded every write cycle
      state <= spi_idle;
      sclk  <= 1'b0;
    end
    else
    begin
      case (state)
        spi_idle:
        begin
          if (count != '0)
            state <= spi_clk_low;     // transfer pending after write
        end
        spi_clk_low:
        begin
          sclk  <= 1'b1;              // rising edge, bit shifted in
          state <= spi_clk_high;
        end
        spi_clk_high:
        begin
          sclk  <= 1'b0;
          count <= count - 4'd1;
          if (count == 4'd1)
            state <= spi_idle;        // last bit, sclk ends low
          else
            state <= spi_clk_low;
        end
        default:
          state <= spi_idle;
      endcase
    end
  end

  // every shift is the rising edge of the serial clock
  a_shift_rises: assert property (@(posedge clk32M) disable iff (clk_reset)
    shift |-> (state == spi_clk_low) ##1 sclk);

  // no stray clock pulse outside a transfer
  a_idle_sclk_low: assert property (@(posedge clk32M) disable iff (clk_reset)
    (state == spi_idle) |-> !sclk);

endmodule

// File: verilog/spi_shift_reg.sv
/* spi data path: lsb first receive, card select and mosi latch
   addr[5:4] selects the device, addr[6] high keeps the old shift data */
module spi_shift_reg (
  input  logic              clk32M,
  input  logic              clk_reset,
  input  logic              sys_reset,   // sync clear
  input  x1_pkg::cpu_bus_t  bus,
  input  logic              load,
  input  logic              shift,
  input  logic              sclk,
  input  logic              miso,
  output x1_pkg::bus_data_t rx_byte,
  output logic              mmc_cs_n,
  output logic              mosi
);
  import x1_pkg::*;

  spi_sel_t  sel;             // bit 0 config rom, not fitted
  bus_data_t sreg;
  logic      rx_bit;

  // only the mmc card returns data, zeros otherwise
  assign rx_bit = sel[1] ? miso : 1'b0;

  // ------------------------------------------------------------
  // select and mosi
  // ------------------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      sel  <= '0;
      mosi <= 1'b0;
    end
    else if (sys_reset)
    begin
      sel  <= '0;
      mosi <= 1'b0;
    end
    else
    begin
      if (load)
        sel <= bus.addr[5:4];
      // mosi only moves while sclk is low
      if (!sclk)
        mosi <= bus.wdata[0];
    end
  end

  assign mmc_cs_n = ~sel[1];

  // ------------------------------------------------------------
  // shift register
  // ------------------------------------------------------------
  always_ff @(posedge clk32M)
  begin
    if (load)
    begin
      if (!bus.addr[6])
        sreg <= bus.wdata;            // preset, usually 8'hff for reads
    end
    else if (shift)
      sreg <= {rx_bit, sreg[7:1]};    // new bit on top, lsb first
  end

  assign rx_byte = sreg;

endmodule

// File: verilog/bus_read_mux.sv
/* cpu read data select, purely combinational
   enables are expected only during a read cycle, priority decides overlaps */
module bus_read_mux (
  input  x1_pkg::dev_sel_t   sel,
  input  x1_pkg::dev_rdata_t rdata,
  input  x1_pkg::bus_data_t  spi_byte,   // spi receive register
  output x1_pkg::bus_data_t  rd_data
);
  import x1_pkg::*;

  // ------------------------------------------------------------
  // fixed priority, fdc highest
  // ------------------------------------------------------------
  always_comb
  begin
    if (sel.fdc_cs)
      rd_data = rdata.fdc;
    else if (sel.sub_doe)
      rd_data = rdata.sub;            // sub cpu / key data
    else if (sel.pia_cs)
      rd_data = rdata.pia;
    else if (sel.psg_cs)
      rd_data = rdata.psg;            // joystick ports
    else if (sel.exrom_cs)
      rd_data = spi_byte;             // expansion rom window reads the spi port
    else if (sel.mem_cs)
      rd_data = rdata.mem;            // ipl, main ram, graphic planes
    else
      rd_data = BUS_FREE;             // nothing drives, pulled high
  end

endmodule

// File: verilog/x1_glue_top.sv
/* x1 glue: clock/reset generator, sd/mmc spi port and cpu read mux
   chip selects and other device read data come from outside */
module x1_glue_top #(
  parameter x1_pkg::clk_phase_t RISE_PHASE = 3'd6,
  parameter x1_pkg::clk_phase_t FALL_PHASE = 3'd2
) (
  input  logic               clk32M,
  input  logic               clk_reset,
  input  logic               ipl_n,
  input  x1_pkg::cpu_bus_t   bus,
  input  x1_pkg::dev_sel_t   sel,
  input  x1_pkg::dev_rdata_t rdata,
  input  logic               miso,      // card data out
  output logic               cpu_clk,
  output logic               cpu_rise,
  output logic               cpu_fall,
  output logic               clk2M,
  output logic               sys_reset,
  output x1_pkg::bus_data_t  rd_data,
  output logic               sclk,
  output logic               mosi,
  output logic               mmc_cs_n
);
  import x1_pkg::*;

  logic      spi_load;
  logic      spi_shift;
  bus_data_t spi_rx;

  // ------------------------------------------------------------
  // clocks and reset
  // ------------------------------------------------------------
  clock_reset_gen #(
    .RISE_PHASE (RISE_PHASE),
    .FALL_PHASE (FALL_PHASE)
  ) u_clock_reset_gen (
    .clk32M    (clk32M),
    .clk_reset (clk_reset),
    .ipl_n     (ipl_n),
    .cpu_clk   (cpu_clk),
    .cpu_rise  (cpu_rise),
    .cpu_fall  (cpu_fall),
    .clk2M     (clk2M),
    .sys_reset (sys_reset)
  );

  // ------------------------------------------------------------
  // spi port
  // ------------------------------------------------------------
  spi_bit_fsm u_spi_bit_fsm (
    .clk32M    (clk32M),
    .clk_reset (clk_reset),
    .sys_reset (sys_reset),
    .bus       (bus),
    .exrom_cs  (sel.exrom_cs),
    .load      (spi_load),
    .shift     (spi_shift),
    .sclk      (sclk)
  );

  spi_shift_reg u_spi_shift_reg (
    .clk32M    (clk32M),
    .clk_reset (clk_reset),
    .sys_reset (sys_reset),
    .bus       (bus),
    .load      (spi_load),
    .shift     (spi_shift),
    .sclk      (sclk),
    .miso      (miso),
    .rx_byte   (spi_rx),
    .mmc_cs_n  (mmc_cs_n),
    .mosi      (mosi)
  );

  // cpu read path
  bus_read_mux u_bus_read_mux (
    .sel       (sel),
    .rdata     (rdata),
    .spi_byte  (spi_rx),
    .rd_data   (rd_data)
  );

endmodule

// File: tb/x1_glue_tests.svh
/* directed tests, included inside the x1_glue_tb module body
   spi_model tracks the receive register, lsb first with card bits entering bit 7 */
`ifndef X1_GLUE_TESTS_SVH
`define X1_GLUE_TESTS_SVH

// ------------------------------------------------------------
// clocks and reset
// ------------------------------------------------------------
task automatic check_reset_values();
  int n;
  clk_reset = 1'b1;
  repeat (RESET_LEN)
  begin
    @(negedge clk32M);
    check_equal(32'(cpu_clk), 0, "cpu_clk in reset");
    check_equal(32'(cpu_rise), 0, "cpu_rise in reset");
    check_equal(32'(cpu_fall), 0, "cpu_fall in reset");
    check_equal(32'(sclk), 0, "sclk in reset");
    check_equal(32'(mosi), 0, "mosi in reset");
    check_equal(32'(mmc_cs_n), 1, "mmc_cs_n in reset");
    check_equal(32'(sys_reset), 1, "sys_reset in reset");
  end
  clk_reset = 1'b0;                        // released on a falling edge
  n = 0;
  while (sys_reset)
  begin
    @(negedge clk32M);
    n++;
  end
  check_equal(n, 16, "sys_reset cycles after release");
endtask

task automatic measure_cpu_clock();
  int   t_rise;
  int   t_fall;
  int   t_next;
  int   t_edge;
  int   high_cnt;
  logic level;
  while (!cpu_rise)
    @(negedge clk32M);
  t_rise = cycle_count;
  while (!cpu_fall)
    @(negedge clk32M);
  t_fall = cycle_count;
  while (!cpu_rise)
    @(negedge clk32M);
  t_next = cycle_count;
  check_equal(t_fall - t_rise, 4, "cpu_fall after cpu_rise");
  check_equal(t_next - t_rise, 8, "cpu_rise spacing");
  high_cnt = 0;
  repeat (8)
  begin
    @(negedge clk32M);
    if (cpu_clk)
      high_cnt++;
  end
  check_equal(high_cnt, 4, "cpu_clk high cycles per 8");
  // clk2M half period
  level = clk2M;
  while (clk2M == level)
    @(negedge clk32M);
  t_edge = cycle_count;
  level  = clk2M;
  while (clk2M == level)
    @(negedge clk32M);
  check_equal(cycle_count - t_edge, 8, "clk2M half period");
endtask

task automatic press_ipl_button();
  int t0;
  int t1;
  while (!cpu_rise)
    @(negedge clk32M);
  t0 = cycle_count;                        // reference rise
  @(negedge clk32M);
  ipl_n = 1'b0;
  #(CLK_PERIOD / 4);
  check_equal(32'(sys_reset), 1, "sys_reset on ipl_n low");
  repeat (4)
    @(negedge clk32M);
  ipl_n = 1'b1;
  #(CLK_PERIOD / 4);
  check_equal(32'(sys_reset), 0, "sys_reset after ipl_n high");
  @(negedge clk32M);
  while (!cpu_rise)
    @(negedge clk32M);
  t1 = cycle_count;
  check_equal((t1 - t0) % 8, 0, "cpu_rise schedule after ipl");
endtask

// ------------------------------------------------------------
// spi port
// ------------------------------------------------------------
task automatic run_spi_transfer(input spi_sel_t dsel, input logic keep, input int nbits,
                                input bus_data_t wd);
  logic [15:0] card;
  logic        b;
  int          pulses;
  int          first_hi;
  int          last_hi;
  int          next_bit;
  int          k;
  card = '0;
  for (k = 0; k < nbits; k++)
  begin
    random_bit(b);
    card[k] = b;
  end
  bus.addr     = {9'b0, keep, dsel, 4'(nbits)};  // keep, select, count
  bus.wdata    = wd;
  bus.wr_n     = 1'b0;
  sel.exrom_cs = 1'b1;
  miso         = card[0];
  @(negedge clk32M);
  bus.wr_n     = 1'b1;                     // wdata stays on the bus
  sel.exrom_cs = 1'b0;
  if (!keep)
    spi_model = wd;
  for (k = 0; k < nbits; k++)
    spi_model = {dsel[1] ? card[k] : 1'b0, spi_model[7:1]};
  pulses   = 0;
  first_hi = -1;
  last_hi  = -1;
  next_bit = 1;
  for (k = 0; k < 2 * nbits + 4; k++)
  begin
    @(negedge clk32M);
    check_equal(32'(mosi), 32'(wd[0]), "mosi holds wdata bit 0");
    check_equal(32'(mmc_cs_n), 32'(!dsel[1]), "mmc_cs_n from select");
    if (sclk)
    begin
      pulses++;
      if (first_hi < 0)
        first_hi = k;
      last_hi  = k;
      miso     = card[next_bit];           // bit for the next rising sclk
      next_bit++;
    end
  end
  check_equal(pulses, nbits, "sclk pulse count");
  check_equal(first_hi, 1, "first sclk after write");
  check_equal(last_hi - first_hi, 2 * (nbits - 1), "sclk pulse spacing");
  check_equal(32'(sclk), 0, "sclk low at end");
endtask

task automatic read_spi_port();
  bus.rd_n     = 1'b0;
  sel.exrom_cs = 1'b1;
  @(negedge clk32M);
  check_equal(32'(rd_data), 32'(spi_model), "spi port read");
  bus.rd_n     = 1'b1;
  sel.exrom_cs = 1'b0;
endtask

task automatic transfer_full_byte();
  bus_data_t wd;
  random_byte(wd);
  run_spi_transfer(2'b10, 1'b0, 8, wd);   // card selected, preset from wdata
  read_spi_port();
endtask

task automatic transfer_partial();
  bus_data_t wd;
  random_byte(wd);
  run_spi_transfer(2'b10, 1'b1, 3, wd);   // old byte moves down 3
  read_spi_port();
  random_byte(wd);
  run_spi_transfer(2'b00, 1'b1, 4, wd);   // no card, zeros in
  read_spi_port();
endtask

// ------------------------------------------------------------
// read data priority
// ------------------------------------------------------------
function automatic bus_data_t expected_read(input dev_sel_t s);
  if (s.fdc_cs)
    return rdata.fdc;                      // highest
  else if (s.sub_doe)
    return rdata.sub;
  else if (s.pia_cs)
    return rdata.pia;
  else if (s.psg_cs)
    return rdata.psg;
  else if (s.exrom_cs)
    return spi_model;
  else if (s.mem_cs)
    return rdata.mem;
  return BUS_FREE;
endfunction

task automatic check_read_priority();
  int s;
  bus.rd_n = 1'b0;
  for (s = 0; s < 64; s++)
  begin
    sel = dev_sel_t'(s[5:0]);              // every enable pattern
    @(negedge clk32M);
    check_equal(32'(rd_data), 32'(expected_read(sel)), "read priority");
  end
  sel      = '0;
  bus.rd_n = 1'b1;
endtask

`endif

// File: tb/x1_glue_tb.sv
/* testbench for the x1 glue logic, assumes the default clock phases 6 and 2
   directed tests come from x1_glue_tests.svh, the first mismatch ends the run */
module x1_glue_tb;
  import x1_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_LEN  = 10;          // cycles of clk_reset

  // budget per test in clk32M cycles, generous upper bounds
  localparam int RESET_TEST_LEN = RESET_LEN + 20;
  localparam int CLOCK_TEST_LEN = 50;      // rise/fall spacing, duty, clk2M
  localparam int IPL_TEST_LEN   = 25;
  localparam int SPI_TEST_LEN   = 50;      // 8 + 3 + 4 bits, 2 cycles each, plus reads
  localparam int READ_TEST_LEN  = 70;      // 64 select patterns
  localparam int TIMEOUT_CYCLES = 2 * (RESET_TEST_LEN + CLOCK_TEST_LEN + IPL_TEST_LEN
                                       + SPI_TEST_LEN + READ_TEST_LEN);

  // ------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------
  logic       clk32M;
  logic       clk_reset;
  logic       ipl_n;
  cpu_bus_t   bus;
  dev_sel_t   sel;
  dev_rdata_t rdata;
  logic       miso;
  logic       cpu_clk;
  logic       cpu_rise;
  logic       cpu_fall;
  logic       clk2M;
  logic       sys_reset;
  bus_data_t  rd_data;
  logic       sclk;
  logic       mosi;
  logic       mmc_cs_n;

  logic [31:0] lfsr_state;
  bus_data_t   spi_model;                  // expected spi receive register
  int          cycle_count = 0;
  int          error_count = 0;

  x1_glue_top #(
    .RISE_PHASE (3'd6),
    .FALL_PHASE (3'd2)
  ) UUT (
    .clk32M    (clk32M),
    .clk_reset (clk_reset),
    .ipl_n     (ipl_n),
    .bus       (bus),
    .sel       (sel),
    .rdata     (rdata),
    .miso      (miso),
    .cpu_clk   (cpu_clk),
    .cpu_rise  (cpu_rise),
    .cpu_fall  (cpu_fall),
    .clk2M     (clk2M),
    .sys_reset (sys_reset),
    .rd_data   (rd_data),
    .sclk      (sclk),
    .mosi      (mosi),
    .mmc_cs_n  (mmc_cs_n)
  );

  // ------------------------------------------------------------
  // clock and run limit
  // ------------------------------------------------------------
  initial
  begin
    clk32M = 1'b0;
    forever #(CLK_PERIOD / 2) clk32M = ~clk32M;
  end

  always @(posedge clk32M)
  begin
    cycle_count <= cycle_count + 1;        // read on falling edges only
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  // ------------------------------------------------------------
  // stimulus source and compare
  // ------------------------------------------------------------
  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] step_lfsr(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bit(output logic b);
    lfsr_state = step_lfsr(lfsr_state);   // one step per bit
    b = lfsr_state[0];
  endtask

  task automatic random_byte(output bus_data_t v);
    logic b;
    int   i;
    for (i = 0; i < 8; i++)
    begin
      random_bit(b);
      v[i] = b;
    end
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp)
    begin
      error_count++;
      $display("Fail at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

`include "x1_glue_tests.svh"

  initial
  begin
    lfsr_state = 32'd72870;
    clk_reset  = 1'b1;
    ipl_n      = 1'b1;
    bus        = '{addr: '0, wdata: '0, rd_n: 1'b1, wr_n: 1'b1};
    sel        = '0;
    rdata      = '{fdc: 8'h1f, sub: 8'h2e, pia: 8'h3d, psg: 8'h4c, mem: 8'h5b};
    miso       = 1'b0;
    spi_model  = '0;
    check_reset_values();
    measure_cpu_clock();
    press_ipl_button();
    transfer_full_byte();
    transfer_partial();
    check_read_priority();
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: list.f
+incdir+tb
verilog/x1_pkg.sv
verilog/clock_reset_gen.sv
verilog/spi_bit_fsm.sv
verilog/spi_shift_reg.sv
verilog/bus_read_mux.sv
verilog/x1_glue_top.sv
tb/x1_glue_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = x1_glue_tb
RTL_TOP   = x1_glue_top
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
